/* Makefile */
TOP = tb_decode_stage

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f $(wildcard logic/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --top-module $(TOP) -f vlog.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

/* logic/ctrl_decoder.sv */
// control decoder
// turns format flags and function fields into the execute, memory,
// branch and writeback controls; anything unknown is flagged illegal
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
    input  decode_ctrl_pkg::fmt_flags_t   fmt,
    input  logic [6:0]                    opcode,
    input  logic [2:0]                    funct3,
    input  logic [4:0]                    lumop,
    output decode_ctrl_pkg::exe_signal_e  exe_signal,
    output decode_ctrl_pkg::vec_operand_e vec_operand,
    output decode_ctrl_pkg::mem_ctrl_e    mem_ctrl,
    output decode_ctrl_pkg::data_size_e   data_size,
    output decode_ctrl_pkg::vls_type_e    vls_type,
    output decode_ctrl_pkg::branch_e      branch,
    output decode_ctrl_pkg::wb_e          wb,
    output logic                          illegal
);

    always_comb begin
        exe_signal  = decode_ctrl_pkg::exe_none;
        vec_operand = decode_ctrl_pkg::not_vec_arith;
        mem_ctrl    = decode_ctrl_pkg::mem_nop;
        data_size   = decode_ctrl_pkg::size_none;
        vls_type    = decode_ctrl_pkg::vls_none;
        branch      = decode_ctrl_pkg::not_branch;
        wb          = decode_ctrl_pkg::wb_nop;
        illegal     = 1'b0;

        if (fmt.p) begin
            if (funct3 == riscv_isa_pkg::f3_csrrs) begin
                exe_signal = decode_ctrl_pkg::exe_read_csr;
                wb         = decode_ctrl_pkg::wb_csr_to_reg;
            end else begin
                illegal = 1'b1;
            end
        end else if (fmt.v) begin
            if (opcode == riscv_isa_pkg::op_vl || opcode == riscv_isa_pkg::op_vs) begin
                exe_signal = decode_ctrl_pkg::exe_mem_addr;
                if (opcode == riscv_isa_pkg::op_vl) begin
                    mem_ctrl = decode_ctrl_pkg::mem_load;
                    wb       = decode_ctrl_pkg::wb_mem_to_reg;
                end else begin
                    mem_ctrl = decode_ctrl_pkg::mem_store;
                end
                case (funct3)  // element width
                    riscv_isa_pkg::f3_v_byte: data_size = decode_ctrl_pkg::size_byte;
                    riscv_isa_pkg::f3_v_half: data_size = decode_ctrl_pkg::size_half;
                    riscv_isa_pkg::f3_v_word: data_size = decode_ctrl_pkg::size_word;
                    default:                  illegal   = 1'b1;
                endcase
                case (lumop)
                    riscv_isa_pkg::lumop_unit:  vls_type = decode_ctrl_pkg::vls_stride;
                    riscv_isa_pkg::lumop_whole: vls_type = decode_ctrl_pkg::vls_whole_reg;
                    riscv_isa_pkg::lumop_mask:  vls_type = decode_ctrl_pkg::vls_mask;
                    default:                    illegal  = 1'b1;
                endcase
            end else if (opcode == riscv_isa_pkg::op_varith) begin
                wb = decode_ctrl_pkg::wb_arith;
                case (funct3)
                    riscv_isa_pkg::f3_opivv, riscv_isa_pkg::f3_opmvv: begin
                        exe_signal  = decode_ctrl_pkg::exe_binary;
                        vec_operand = decode_ctrl_pkg::vec_vec;
                    end
                    riscv_isa_pkg::f3_opivi: begin
                        exe_signal  = decode_ctrl_pkg::exe_imm_binary;
                        vec_operand = decode_ctrl_pkg::vec_imm;
                    end
                    riscv_isa_pkg::f3_opivx, riscv_isa_pkg::f3_opmvx: begin
                        exe_signal  = decode_ctrl_pkg::exe_binary;
                        vec_operand = decode_ctrl_pkg::vec_scalar;
                    end
                    default: illegal = 1'b1;  // opcfg and float categories
                endcase
            end else begin
                illegal = 1'b1;
            end
        end else if (fmt.r) begin
            wb = decode_ctrl_pkg::wb_arith;
            case (opcode)
                riscv_isa_pkg::op_op:     exe_signal = decode_ctrl_pkg::exe_binary;
                riscv_isa_pkg::op_op_imm: exe_signal = decode_ctrl_pkg::exe_imm_binary;
                riscv_isa_pkg::op_op_32:  exe_signal = decode_ctrl_pkg::exe_binary_word;
                default:                  illegal    = 1'b1;
            endcase
        end else if (fmt.i) begin
            case (opcode)
                riscv_isa_pkg::op_op_imm: begin
                    exe_signal = decode_ctrl_pkg::exe_imm_binary;
                    wb         = decode_ctrl_pkg::wb_arith;
                end
                riscv_isa_pkg::op_op_imm_32: begin
                    exe_signal = decode_ctrl_pkg::exe_imm_binary_word;
                    wb         = decode_ctrl_pkg::wb_arith;
                end
                riscv_isa_pkg::op_load: begin
                    exe_signal = decode_ctrl_pkg::exe_mem_addr;
                    mem_ctrl   = decode_ctrl_pkg::mem_load;
                    wb         = decode_ctrl_pkg::wb_mem_to_reg;
                    case (funct3)
                        riscv_isa_pkg::f3_w_byte: data_size = decode_ctrl_pkg::size_byte;
                        riscv_isa_pkg::f3_w_half: data_size = decode_ctrl_pkg::size_half;
                        riscv_isa_pkg::f3_w_word: data_size = decode_ctrl_pkg::size_word;
                        default:                  illegal   = 1'b1;
                    endcase
                end
                riscv_isa_pkg::op_jalr: begin
                    exe_signal = decode_ctrl_pkg::exe_mem_addr;  // rs1 + imm
                    branch     = decode_ctrl_pkg::unconditional_result;
                    wb         = decode_ctrl_pkg::wb_increased_pc;
                end
                default: illegal = 1'b1;
            endcase
        end else if (fmt.s) begin
            exe_signal = decode_ctrl_pkg::exe_mem_addr;
            mem_ctrl   = decode_ctrl_pkg::mem_store;
            case (funct3)
                riscv_isa_pkg::f3_w_byte: data_size = decode_ctrl_pkg::size_byte;
                riscv_isa_pkg::f3_w_half: data_size = decode_ctrl_pkg::size_half;
                riscv_isa_pkg::f3_w_word: data_size = decode_ctrl_pkg::size_word;
                default:                  illegal   = 1'b1;
            endcase
        end else if (fmt.b) begin
            exe_signal = decode_ctrl_pkg::exe_branch_cond;
            branch     = decode_ctrl_pkg::conditional;
        end else if (fmt.u) begin
            wb = decode_ctrl_pkg::wb_arith;
            if (opcode == riscv_isa_pkg::op_lui) begin
                exe_signal = decode_ctrl_pkg::exe_imm;
            end else begin
                exe_signal = decode_ctrl_pkg::exe_pc_based;
            end
        end else if (fmt.j) begin
            exe_signal = decode_ctrl_pkg::exe_pc_based;
            branch     = decode_ctrl_pkg::unconditional;
            wb         = decode_ctrl_pkg::wb_increased_pc;
        end else begin
            illegal = 1'b1;  // no format matched
        end

        // partial decodes must not leak out
        if (illegal) begin
            exe_signal  = decode_ctrl_pkg::exe_none;
            vec_operand = decode_ctrl_pkg::not_vec_arith;
            mem_ctrl    = decode_ctrl_pkg::mem_nop;
            data_size   = decode_ctrl_pkg::size_none;
            vls_type    = decode_ctrl_pkg::vls_none;
            branch      = decode_ctrl_pkg::not_branch;
            wb          = decode_ctrl_pkg::wb_nop;
        end
    end

endmodule

`default_nettype wire

/* logic/decode_ctrl_pkg.sv */
// decode control fields
// encodings of the control outputs handed to execute, memory and writeback
`default_nettype none

package decode_ctrl_pkg;

    // idle value kept at zero
    typedef enum logic [3:0] {
        exe_binary          = 4'd1,
        exe_imm_binary      = 4'd2,
        exe_binary_word     = 4'd3,
        exe_imm_binary_word = 4'd4,
        exe_mem_addr        = 4'd5,
        exe_branch_cond     = 4'd6,
        exe_imm             = 4'd7,
        exe_pc_based        = 4'd8,
        exe_read_csr        = 4'd9,
        exe_none            = 4'd0
    } exe_signal_e;

    typedef enum logic [1:0] {not_vec_arith, vec_vec, vec_scalar, vec_imm} vec_operand_e;

    typedef enum logic [1:0] {mem_nop, mem_load, mem_store} mem_ctrl_e;

    typedef enum logic [1:0] {size_none, size_byte, size_half, size_word} data_size_e;

    typedef enum logic [1:0] {vls_none, vls_stride, vls_whole_reg, vls_mask} vls_type_e;

    typedef enum logic [1:0] {
        not_branch,
        conditional,
        unconditional,
        unconditional_result   // jalr, target from alu
    } branch_e;

    typedef enum logic [2:0] {
        wb_nop,
        wb_arith,
        wb_mem_to_reg,
        wb_increased_pc,
        wb_csr_to_reg
    } wb_e;

    // one hot, all zero when the word is not recognised
    typedef struct packed {
        logic p;
        logic v;
        logic r;
        logic i;
        logic s;
        logic b;
        logic u;
        logic j;
    } fmt_flags_t;

endpackage

`default_nettype wire

/* logic/decode_stage.sv */
// decode stage
// registered rv64 + vector decode: one instruction in per strobe,
// indices, immediate and controls out one clock later
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int xlen = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          instr_valid,
    input  logic [31:0]                   instruction,
    output logic                          decode_valid,
    output logic [4:0]                    rs1,
    output logic [4:0]                    rs2,
    output logic [4:0]                    rd,
    output logic [11:0]                   csr_addr,
    output logic                          vm,
    output logic [5:0]                    func6,
    output logic [3:0]                    func_code,
    output logic [xlen-1:0]               immediate,
    output decode_ctrl_pkg::exe_signal_e  exe_signal,
    output decode_ctrl_pkg::vec_operand_e vec_operand,
    output decode_ctrl_pkg::mem_ctrl_e    mem_ctrl,
    output decode_ctrl_pkg::data_size_e   data_size,
    output decode_ctrl_pkg::vls_type_e    vls_type,
    output decode_ctrl_pkg::branch_e      branch,
    output decode_ctrl_pkg::wb_e          wb,
    output logic                          is_vector,
    output logic                          illegal
);

    riscv_isa_pkg::instr_word_u    word;
    decode_ctrl_pkg::fmt_flags_t   fmt;
    logic [3:0]                    func_code_c;
    logic [xlen-1:0]               imm_c;
    decode_ctrl_pkg::exe_signal_e  exe_c;
    decode_ctrl_pkg::vec_operand_e vec_operand_c;
    decode_ctrl_pkg::mem_ctrl_e    mem_c;
    decode_ctrl_pkg::data_size_e   size_c;
    decode_ctrl_pkg::vls_type_e    vls_c;
    decode_ctrl_pkg::branch_e      branch_c;
    decode_ctrl_pkg::wb_e          wb_c;
    logic                          illegal_c;

    assign word        = instruction;
    assign func_code_c = {word.scalar.funct7[5], word.scalar.funct3};  // bit 30 + funct3

    instr_classifier instr_classifier_i (
        .opcode    (word.scalar.opcode),
        .func_code (func_code_c),
        .fmt       (fmt)
    );

    imm_gen #(
        .xlen (xlen)
    ) imm_gen_i (
        .instruction (instruction),
        .fmt         (fmt),
        .imm         (imm_c)
    );

    ctrl_decoder ctrl_decoder_i (
        .fmt         (fmt),
        .opcode      (word.scalar.opcode),
        .funct3      (word.scalar.funct3),
        .lumop       (word.vector.vs2),
        .exe_signal  (exe_c),
        .vec_operand (vec_operand_c),
        .mem_ctrl    (mem_c),
        .data_size   (size_c),
        .vls_type    (vls_c),
        .branch      (branch_c),
        .wb          (wb_c),
        .illegal     (illegal_c)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_valid <= 1'b0;
            rs1          <= '0;
            rs2          <= '0;
            rd           <= '0;
            csr_addr     <= '0;
            vm           <= 1'b0;
            func6        <= '0;
            func_code    <= '0;
            immediate    <= '0;
            exe_signal   <= decode_ctrl_pkg::exe_none;
            vec_operand  <= decode_ctrl_pkg::not_vec_arith;
            mem_ctrl     <= decode_ctrl_pkg::mem_nop;
            data_size    <= decode_ctrl_pkg::size_none;
            vls_type     <= decode_ctrl_pkg::vls_none;
            branch       <= decode_ctrl_pkg::not_branch;
            wb           <= decode_ctrl_pkg::wb_nop;
            is_vector    <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            decode_valid <= instr_valid;
            if (instr_valid) begin  // fields hold between strobes
                rs1         <= word.scalar.rs1;
                rs2         <= word.scalar.rs2;
                rd          <= word.scalar.rd;
                csr_addr    <= {word.scalar.funct7, word.scalar.rs2};
                vm          <= word.vector.vm;
                func6       <= word.vector.funct6;
                func_code   <= func_code_c;
                immediate   <= imm_c;
                exe_signal  <= exe_c;
                vec_operand <= vec_operand_c;
                mem_ctrl    <= mem_c;
                data_size   <= size_c;
                vls_type    <= vls_c;
                branch      <= branch_c;
                wb          <= wb_c;
                is_vector   <= fmt.v;
                illegal     <= illegal_c;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/imm_gen.sv */
// immediate generator
// assembles the immediate of the detected format and sign extends it
// to xlen bits
`timescale 1ns/1ps
`default_nettype none

module imm_gen #(
    parameter int xlen = 64
) (
    input  logic [31:0]                 instruction,
    input  decode_ctrl_pkg::fmt_flags_t fmt,
    output logic [xlen-1:0]             imm
);

    logic        sign_bit;
    logic [31:0] imm32;

    assign sign_bit = instruction[31];

    always_comb begin
        if (fmt.p) begin
            imm32 = {27'b0, instruction[19:15]};  // csr uimm, zero extended
        end else if (fmt.v) begin
            imm32 = {{27{instruction[19]}}, instruction[19:15]};  // simm5
        end else if (fmt.r) begin
            imm32 = '0;  // shamt stays in rs2
        end else if (fmt.i) begin
            imm32 = {{20{sign_bit}}, instruction[31:20]};
        end else if (fmt.s) begin
            imm32 = {{20{sign_bit}}, instruction[31:25], instruction[11:7]};
        end else if (fmt.b) begin
            imm32 = {{20{sign_bit}}, instruction[7], instruction[30:25],
                     instruction[11:8], 1'b0};
        end else if (fmt.u) begin
            imm32 = {instruction[31:12], 12'b0};
        end else if (fmt.j) begin
            imm32 = {{12{sign_bit}}, instruction[19:12], instruction[20],
                     instruction[30:21], 1'b0};
        end else begin
            imm32 = '0;
        end
    end

    // bit 31 is the sign for every format, zero for p
    assign imm = xlen'(signed'(imm32));

endmodule

`default_nettype wire

/* logic/instr_classifier.sv */
// instruction classifier
// sorts the opcode and function code into one hot format flags
`timescale 1ns/1ps
`default_nettype none

module instr_classifier (
    input  logic [6:0]                  opcode,
    input  logic [3:0]                  func_code,
    output decode_ctrl_pkg::fmt_flags_t fmt
);

    logic shift_imm;
    logic f3_zero;

    // slli, srli, srai
    assign shift_imm = (func_code == 4'b0001) || (func_code == 4'b0101) ||
                       (func_code == 4'b1101);
    assign f3_zero   = func_code[2:0] == 3'b000;

    always_comb begin
        fmt   = '0;
        fmt.p = opcode == riscv_isa_pkg::op_system;
        fmt.v = (opcode == riscv_isa_pkg::op_vl) || (opcode == riscv_isa_pkg::op_vs) ||
                (opcode == riscv_isa_pkg::op_varith);
        fmt.r = (opcode == riscv_isa_pkg::op_op) || (opcode == riscv_isa_pkg::op_op_32) ||
                (opcode == riscv_isa_pkg::op_op_imm && shift_imm);
        fmt.i = (opcode == riscv_isa_pkg::op_op_imm && !shift_imm) ||
                (opcode == riscv_isa_pkg::op_load) ||
                (opcode == riscv_isa_pkg::op_jalr && f3_zero) ||
                (opcode == riscv_isa_pkg::op_op_imm_32 && f3_zero);  // addiw only
        fmt.s = opcode == riscv_isa_pkg::op_store;
        fmt.b = opcode == riscv_isa_pkg::op_branch;
        fmt.u = (opcode == riscv_isa_pkg::op_lui) || (opcode == riscv_isa_pkg::op_auipc);
        fmt.j = opcode == riscv_isa_pkg::op_jal;  // 14:12 are imm bits here
    end

endmodule

`default_nettype wire

/* logic/riscv_isa_pkg.sv */
// riscv isa encodings
// opcodes, funct3 codes, vector width and lumop codes, and the
// instruction word seen as scalar or vector fields
`default_nettype none

package riscv_isa_pkg;

    localparam logic [6:0] op_load      = 7'b0000011;
    localparam logic [6:0] op_op_imm    = 7'b0010011;
    localparam logic [6:0] op_op_imm_32 = 7'b0011011;
    localparam logic [6:0] op_auipc     = 7'b0010111;
    localparam logic [6:0] op_store     = 7'b0100011;
    localparam logic [6:0] op_op        = 7'b0110011;
    localparam logic [6:0] op_op_32     = 7'b0111011;
    localparam logic [6:0] op_lui       = 7'b0110111;
    localparam logic [6:0] op_branch    = 7'b1100011;
    localparam logic [6:0] op_jalr      = 7'b1100111;
    localparam logic [6:0] op_jal       = 7'b1101111;
    localparam logic [6:0] op_system    = 7'b1110011;
    localparam logic [6:0] op_vl        = 7'b0000111;  // load-fp space
    localparam logic [6:0] op_vs        = 7'b0100111;  // store-fp space
    localparam logic [6:0] op_varith    = 7'b1010111;

    localparam logic [2:0] f3_csrrs = 3'b010;

    // op-v categories, opcfg (111) not handled
    localparam logic [2:0] f3_opivv = 3'b000;
    localparam logic [2:0] f3_opmvv = 3'b010;
    localparam logic [2:0] f3_opivi = 3'b011;
    localparam logic [2:0] f3_opivx = 3'b100;
    localparam logic [2:0] f3_opmvx = 3'b110;

    localparam logic [2:0] f3_w_byte = 3'b000;
    localparam logic [2:0] f3_w_half = 3'b001;
    localparam logic [2:0] f3_w_word = 3'b010;

    localparam logic [2:0] f3_v_byte = 3'b000;
    localparam logic [2:0] f3_v_half = 3'b101;
    localparam logic [2:0] f3_v_word = 3'b110;

    localparam logic [4:0] lumop_unit  = 5'b00000;
    localparam logic [4:0] lumop_whole = 5'b01000;
    localparam logic [4:0] lumop_mask  = 5'b01011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } scalar_fields_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;    // lumop for vl/vs
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } vector_fields_t;

    typedef union packed {
        scalar_fields_t scalar;
        vector_fields_t vector;
    } instr_word_u;

endpackage

`default_nettype wire

/* test/decode_patterns.txt */
// instruction word _ expected nibbles: exe vec mem size vls branch wb flags
// flags nibble holds illegal in bit 1 and is_vector in bit 0
C00022F3_90000040 // csrrs x5, cycle, x0
002081B3_10000010 // add
002081BB_30000010 // addw
4050D193_20000010 // srai
FFF08193_20000010 // addi -1
0070819B_40000010 // addiw
00408183_50110020 // lb
00409183_50120020 // lh
0040A183_50130020 // lw
00208423_50210000 // sb
00209423_50220000 // sh
0020A423_50230000 // sw
00208863_60000100 // beq
123452B7_70000010 // lui
00001297_80000010 // auipc
000010EF_80000230 // jal, nonzero 14:12
000280E7_50000330 // jalr
02010087_50111021 // vle8 unit
02815087_50122021 // vl1re16 whole reg
02B16087_50133021 // vlm, word width
020160A7_50231001 // vse32 unit
022180D7_11000011 // opivv
0221A0D7_11000011 // opmvv
0221B0D7_23000011 // opivi
0221C0D7_12000011 // opivx
0221E0D7_12000011 // opmvx
0000007F_00000002 // unknown opcode
0040B183_00000002 // ld, width not supported
02110087_00000003 // vle8 with bad lumop
000070D7_00000003 // opcfg

/* test/tb_decode_stage.sv */
// decode stage testbench
// replays instruction patterns, checks random immediates and the
// strobe timing of the output register
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    localparam int xlen         = 64;
    localparam int num_patterns = 30;
    localparam int num_random   = 40;
    localparam int watchdog_ns  = (num_patterns + num_random + 10) * 20 * 4;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          instr_valid;
    logic [31:0]                   instruction;
    logic                          decode_valid;
    logic [4:0]                    rs1;
    logic [4:0]                    rs2;
    logic [4:0]                    rd;
    logic [11:0]                   csr_addr;
    logic                          vm;
    logic [5:0]                    func6;
    logic [3:0]                    func_code;
    logic [xlen-1:0]               immediate;
    decode_ctrl_pkg::exe_signal_e  exe_signal;
    decode_ctrl_pkg::vec_operand_e vec_operand;
    decode_ctrl_pkg::mem_ctrl_e    mem_ctrl;
    decode_ctrl_pkg::data_size_e   data_size;
    decode_ctrl_pkg::vls_type_e    vls_type;
    decode_ctrl_pkg::branch_e      branch;
    decode_ctrl_pkg::wb_e          wb;
    logic                          is_vector;
    logic                          illegal;

    logic [63:0] patterns [num_patterns];  // word in 63:32, control nibbles below
    logic [31:0] lfsr_state = 32'h406ee99a;
    int          tp_sel [3] = '{1, 20, 23};  // add, vse32, opivi

    decode_stage #(
        .xlen (xlen)
    ) decode_stage_i (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instruction  (instruction),
        .decode_valid (decode_valid),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .csr_addr     (csr_addr),
        .vm           (vm),
        .func6        (func6),
        .func_code    (func_code),
        .immediate    (immediate),
        .exe_signal   (exe_signal),
        .vec_operand  (vec_operand),
        .mem_ctrl     (mem_ctrl),
        .data_size    (data_size),
        .vls_type     (vls_type),
        .branch       (branch),
        .wb           (wb),
        .is_vector    (is_vector),
        .illegal      (illegal)
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_exe(input decode_ctrl_pkg::exe_signal_e got,
                             input decode_ctrl_pkg::exe_signal_e exp);
        if (got !== exp) begin
            $display("FAILED exe_signal got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_vec_operand(input decode_ctrl_pkg::vec_operand_e got,
                                     input decode_ctrl_pkg::vec_operand_e exp);
        if (got !== exp) begin
            $display("FAILED vec_operand got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_mem(input decode_ctrl_pkg::mem_ctrl_e got,
                             input decode_ctrl_pkg::mem_ctrl_e exp);
        if (got !== exp) begin
            $display("FAILED mem_ctrl got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_size(input decode_ctrl_pkg::data_size_e got,
                              input decode_ctrl_pkg::data_size_e exp);
        if (got !== exp) begin
            $display("FAILED data_size got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_vls(input decode_ctrl_pkg::vls_type_e got,
                             input decode_ctrl_pkg::vls_type_e exp);
        if (got !== exp) begin
            $display("FAILED vls_type got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_branch(input decode_ctrl_pkg::branch_e got,
                                input decode_ctrl_pkg::branch_e exp);
        if (got !== exp) begin
            $display("FAILED branch got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_wb(input decode_ctrl_pkg::wb_e got, input decode_ctrl_pkg::wb_e exp);
        if (got !== exp) begin
            $display("FAILED wb got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_index(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_csr_addr(input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp) begin
            $display("FAILED csr_addr got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_func6(input logic [5:0] got, input logic [5:0] exp);
        if (got !== exp) begin
            $display("FAILED func6 got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_func_code(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAILED func_code got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_imm(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("FAILED immediate got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    // nibbles: exe vec mem size vls branch wb {illegal, is_vector}
    task automatic compare_controls(input logic [31:0] exp);
        check_exe(exe_signal, decode_ctrl_pkg::exe_signal_e'(exp[31:28]));
        check_vec_operand(vec_operand, decode_ctrl_pkg::vec_operand_e'(exp[25:24]));
        check_mem(mem_ctrl, decode_ctrl_pkg::mem_ctrl_e'(exp[21:20]));
        check_size(data_size, decode_ctrl_pkg::data_size_e'(exp[17:16]));
        check_vls(vls_type, decode_ctrl_pkg::vls_type_e'(exp[13:12]));
        check_branch(branch, decode_ctrl_pkg::branch_e'(exp[9:8]));
        check_wb(wb, decode_ctrl_pkg::wb_e'(exp[6:4]));
        check_flag("illegal", illegal, exp[1]);
        check_flag("is_vector", is_vector, exp[0]);
    endtask

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[b]       = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // kind: 0 i, 1 s, 2 b, 3 u, 4 j
    function automatic logic [xlen-1:0] expected_imm(input logic [31:0] w, input int kind);
        logic signed [11:0] i12;
        logic signed [12:0] b13;
        logic signed [31:0] u32;
        logic signed [20:0] j21;
        longint             v;
        i12 = w[31:20];
        b13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        u32 = {w[31:12], 12'b0};
        j21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (kind)
            0: v = longint'(i12);
            1: begin
                i12 = {w[31:25], w[11:7]};
                v   = longint'(i12);
            end
            2: v = longint'(b13);
            3: v = longint'(u32);
            4: v = longint'(j21);
            default: v = 0;
        endcase
        return v[xlen-1:0];
    endfunction

    task automatic apply_instr(input logic [31:0] w);
        @(negedge clk);
        instr_valid = 1'b1;
        instruction = w;
        @(negedge clk);
        instr_valid = 1'b0;
        while (decode_valid !== 1'b1) @(negedge clk);
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: the decode tests did not complete in time");
        stop_with_failure();
    end

    initial begin
        riscv_isa_pkg::instr_word_u w;
        logic [31:0]                bits;
        logic [6:0]                 opc;
        int                         kind;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instruction = '0;
        $readmemh("test/decode_patterns.txt", patterns);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        check_flag("decode_valid", decode_valid, 1'b0);
        compare_controls(32'h0);
        check_imm(immediate, '0);
        check_index("rs1", rs1, 5'd0);
        check_index("rs2", rs2, 5'd0);
        check_index("rd", rd, 5'd0);

        for (int i = 0; i < num_patterns; i++) begin
            apply_instr(patterns[i][63:32]);
            compare_controls(patterns[i][31:0]);
        end

        for (int k = 0; k < num_random; k++) begin
            random_bits(3, bits);
            kind = int'(bits[2:0]) % 5;
            case (kind)
                0:       opc = riscv_isa_pkg::op_load;
                1:       opc = riscv_isa_pkg::op_store;
                2:       opc = riscv_isa_pkg::op_branch;
                3:       opc = riscv_isa_pkg::op_lui;
                default: opc = riscv_isa_pkg::op_jal;
            endcase
            random_bits(25, bits);
            w = {bits[24:0], opc};
            apply_instr(w);
            check_imm(immediate, expected_imm(w, kind));
            check_index("rs1", rs1, w[19:15]);
            check_index("rs2", rs2, w[24:20]);
            check_index("rd", rd, w[11:7]);
            check_csr_addr(csr_addr, w[31:20]);
            check_flag("vm", vm, w[25]);
            check_func6(func6, w[31:26]);
            check_func_code(func_code, {w[30], w[14:12]});
        end

        // back to back strobes, then a gap
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            if (k > 0) begin
                check_flag("decode_valid", decode_valid, 1'b1);
                compare_controls(patterns[tp_sel[k-1]][31:0]);
            end
            if (k < 3) begin
                instr_valid = 1'b1;
                instruction = patterns[tp_sel[k]][63:32];
            end else begin
                instr_valid = 1'b0;
                instruction = patterns[tp_sel[0]][63:32];  // must not get through
            end
        end
        w = patterns[tp_sel[2]][63:32];
        repeat (2) begin
            @(negedge clk);
            check_flag("decode_valid", decode_valid, 1'b0);
            compare_controls(patterns[tp_sel[2]][31:0]);
            check_index("rd", rd, w.scalar.rd);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/riscv_isa_pkg.sv
logic/decode_ctrl_pkg.sv
logic/instr_classifier.sv
logic/imm_gen.sv
logic/ctrl_decoder.sv
logic/decode_stage.sv
test/tb_decode_stage.sv
